/* Makefile */
SIM        = verilator
TOP        = tb_adc_panel
FILELIST   = sources.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
RUN_FLAGS  = +verilator+error+limit+100

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* adc_panel_top.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_panel_top #(
    parameter int SCL_DIV        = 4,
    parameter int STRETCH_CYCLES = 2048,
    parameter int GAP_CYCLES     = 16
) (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    // APB slave
    input  wire logic                           psel_i,
    input  wire logic                           penable_i,
    input  wire logic [bus_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic                           pwrite_i,
    input  wire logic [bus_pkg::apb_data_w-1:0] pwdata_i,
    output logic      [bus_pkg::apb_data_w-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    // ADC overrange
    input  wire logic                           adc_dora_i,
    input  wire logic                           adc_dorb_i,
    // Front-end expander
    output logic                                adc_io_scl_o,
    output logic                                adc_io_sda_o
);

    import bus_pkg::*;
    import panel_pkg::*;

    logic                  sel_ina;
    logic                  sel_inb;
    logic [apb_data_w-1:0] rdata_ina;
    logic [apb_data_w-1:0] rdata_inb;

    logic [att_w-1:0]  ina_att;
    logic              ina_amp_en;
    logic [led_w-1:0]  ina_led;
    logic [att_w-1:0]  inb_att;
    logic              inb_amp_en;
    logic [led_w-1:0]  inb_led;
    logic              ovr_a;
    logic              ovr_b;
    logic [port_w-1:0] panel_io;

    // Zero wait, never an error
    assign pready_o  = 1'b1;
    assign pslverr_o = 1'b0;

    ////////////////////
    // Register access
    ////////////////////
    apb_slot_decode i_slot_decode (
        .psel_i      (psel_i),
        .paddr_i     (paddr_i),
        .rdata_ina_i (rdata_ina),
        .rdata_inb_i (rdata_inb),
        .sel_ina_o   (sel_ina),
        .sel_inb_o   (sel_inb),
        .prdata_o    (prdata_o)
    );

    chan_regs i_regs_ina (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .sel_i     (sel_ina),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .rdata_o   (rdata_ina),
        .ovr_i     (ovr_a),
        .att_o     (ina_att),
        .amp_en_o  (ina_amp_en),
        .led_o     (ina_led)
    );

    chan_regs i_regs_inb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .sel_i     (sel_inb),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .rdata_o   (rdata_inb),
        .ovr_i     (ovr_b),
        .att_o     (inb_att),
        .amp_en_o  (inb_amp_en),
        .led_o     (inb_led)
    );

    ////////////////////
    // Overrange hold
    ////////////////////
    overrange_stretch #(.STRETCH_CYCLES(STRETCH_CYCLES)) i_stretch_a (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dor_i   (adc_dora_i),
        .flag_o  (ovr_a)
    );

    overrange_stretch #(.STRETCH_CYCLES(STRETCH_CYCLES)) i_stretch_b (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dor_i   (adc_dorb_i),
        .flag_o  (ovr_b)
    );

    ////////////////////
    // Expander path
    ////////////////////
    panel_word i_panel_word (
        .att_a_i (ina_att),
        .amp_a_i (ina_amp_en),
        .led_a_i (ina_led),
        .ovr_a_i (ovr_a),
        .att_b_i (inb_att),
        .amp_b_i (inb_amp_en),
        .led_b_i (inb_led),
        .ovr_b_i (ovr_b),
        .word_o  (panel_io)
    );

    // Push-pull lines, idle high
    ioexp_writer #(
        .SCL_DIV    (SCL_DIV),
        .GAP_CYCLES (GAP_CYCLES)
    ) i_ioexp_writer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .word_i  (panel_io),
        .scl_o   (adc_io_scl_o),
        .sda_o   (adc_io_sda_o)
    );

endmodule

`default_nettype wire

/* apb_slot_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_slot_decode (
    input  wire logic                           psel_i,
    input  wire logic [bus_pkg::apb_addr_w-1:0] paddr_i,
    input  wire logic [bus_pkg::apb_data_w-1:0] rdata_ina_i,
    input  wire logic [bus_pkg::apb_data_w-1:0] rdata_inb_i,
    output logic                                sel_ina_o,
    output logic                                sel_inb_o,
    output logic      [bus_pkg::apb_data_w-1:0] prdata_o
);

    import bus_pkg::*;

    // Page match on the bits above the slot nibble
    logic              page_hit;
    logic [slot_w-1:0] slot;

    assign page_hit = psel_i &&
        (paddr_i[apb_addr_w-1:slot_lsb+slot_w] == slot_base[apb_addr_w-slot_lsb-1:slot_w]);

    // Slot nibble, one per channel
    assign slot = paddr_i[slot_lsb +: slot_w];

    assign sel_ina_o = page_hit && (slot == SLOT_INA);
    assign sel_inb_o = page_hit && (slot == SLOT_INB);

    ////////////////////
    // Read data return
    ////////////////////
    always_comb begin
        if (sel_ina_o) begin
            prdata_o = rdata_ina_i;
        end else if (sel_inb_o) begin
            prdata_o = rdata_inb_i;
        end else begin
            // Unmapped slot or idle bus
            prdata_o = '0;
        end
    end

endmodule

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

    ////////////////////
    // APB widths
    ////////////////////
    localparam int apb_addr_w = 32;
    localparam int apb_data_w = 32;

    // Panel region page, slot nibble included
    localparam logic [19:0] slot_base = 20'h43C00;
    localparam int slot_lsb = 12;
    localparam int slot_w = 4;

    // Slot field values, the rest unmapped
    typedef enum logic [slot_w-1:0] {
        SLOT_INA = 4'h0,
        SLOT_INB = 4'h1
    } slot_e;

    ////////////////////
    // Register map
    ////////////////////
    localparam int reg_off_w = 12;

    typedef enum logic [reg_off_w-1:0] {
        REG_CTRL   = 12'h000,
        REG_LED    = 12'h004,
        REG_STATUS = 12'h008
    } reg_e;

    // CTRL field layout
    localparam int ctrl_att_lsb = 0;
    localparam int ctrl_amp_bit = 2;
    // STATUS field layout
    localparam int status_ovr_bit = 0;

    localparam logic [apb_data_w-1:0] ctrl_reset = '0;

endpackage

`default_nettype wire

/* chan_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module chan_regs (
    input  wire logic                             clk_i,
    input  wire logic                             rst_n_i,
    input  wire logic                             sel_i,
    input  wire logic                             penable_i,
    input  wire logic                             pwrite_i,
    input  wire logic [bus_pkg::apb_addr_w-1:0]   paddr_i,
    input  wire logic [bus_pkg::apb_data_w-1:0]   pwdata_i,
    output logic      [bus_pkg::apb_data_w-1:0]   rdata_o,
    input  wire logic                             ovr_i,
    output logic      [panel_pkg::att_w-1:0]      att_o,
    output logic                                  amp_en_o,
    output logic      [panel_pkg::led_w-1:0]      led_o
);

    import bus_pkg::*;
    import panel_pkg::*;

    logic                 wr_en;
    logic [reg_off_w-1:0] reg_off;

    // Offset inside the slot
    assign reg_off = paddr_i[reg_off_w-1:0];

    // Access phase write, completes on this edge
    assign wr_en = sel_i && penable_i && pwrite_i;

    ////////////////////
    // Control fields
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            att_o    <= ctrl_reset[ctrl_att_lsb +: att_w];
            amp_en_o <= ctrl_reset[ctrl_amp_bit];
            led_o    <= ctrl_reset[led_w-1:0];
        end else if (wr_en) begin
            // CTRL holds attenuator and amp enable
            if (reg_off == REG_CTRL) begin
                att_o    <= pwdata_i[ctrl_att_lsb +: att_w];
                amp_en_o <= pwdata_i[ctrl_amp_bit];
            end
            // LED as red, green, blue from the top
            if (reg_off == REG_LED) begin
                led_o <= pwdata_i[led_w-1:0];
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rdata_o = '0;
        case (reg_off)
            REG_CTRL: begin
                rdata_o[ctrl_att_lsb +: att_w] = att_o;
                rdata_o[ctrl_amp_bit]          = amp_en_o;
            end
            REG_LED: begin
                rdata_o[led_w-1:0] = led_o;
            end
            REG_STATUS: begin
                // Stretched overrange, read only
                rdata_o[status_ovr_bit] = ovr_i;
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* ioexp_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_writer #(
    parameter int SCL_DIV    = 4,
    parameter int GAP_CYCLES = 16
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_n_i,
    input  wire logic [panel_pkg::port_w-1:0] word_i,
    output logic                              scl_o,
    output logic                              sda_o
);

    import panel_pkg::*;

    // One counter covers half periods, STOP and the gap
    localparam int cnt_max = (2 * SCL_DIV > GAP_CYCLES) ? 2 * SCL_DIV : GAP_CYCLES;
    localparam int cnt_w = $clog2(cnt_max + 1);

    i2c_state_e        state_q;
    logic [cnt_w-1:0]  cnt_q;
    logic [3:0]        bit_cnt;
    logic [1:0]        byte_cnt;
    logic [7:0]        shift_q;
    logic [port_w-1:0] word_q;
    logic [7:0]        next_byte;

    // Byte after the one just finished
    always_comb begin
        case (byte_cnt)
            2'd0:    next_byte = exp_cmd_out0;
            2'd1:    next_byte = word_q[7:0];
            default: next_byte = word_q[port_w-1:8];
        endcase
    end

    ////////////////////
    // Frame FSM
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            cnt_q    <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            scl_o    <= 1'b1;
            sda_o    <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                // Bus idle, both lines high
                IDLE, GAP: begin
                    if (cnt_q == cnt_w'(GAP_CYCLES - 1)) begin
                        state_q <= START;
                        cnt_q   <= '0;
                        // Start condition, SDA falls under high SCL
                        sda_o   <= 1'b0;
                    end
                end
                START: begin
                    if (cnt_q == cnt_w'(SCL_DIV - 1)) begin
                        state_q  <= BIT_LOW;
                        cnt_q    <= '0;
                        scl_o    <= 1'b0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                BIT_LOW: begin
                    // Data moves one cycle after SCL fell
                    if (cnt_q == '0) begin
                        sda_o <= (bit_cnt == 4'd8) ? 1'b1 : shift_q[7];
                    end
                    if (cnt_q == cnt_w'(SCL_DIV - 1)) begin
                        state_q <= BIT_HIGH;
                        cnt_q   <= '0;
                        scl_o   <= 1'b1;
                    end
                end
                BIT_HIGH: begin
                    if (cnt_q == cnt_w'(SCL_DIV - 1)) begin
                        cnt_q <= '0;
                        scl_o <= 1'b0;
                        if (bit_cnt == 4'd8) begin
                            // ACK clock done, ack not sampled
                            bit_cnt <= '0;
                            if (byte_cnt == 2'd3) begin
                                state_q <= STOP;
                            end else begin
                                state_q  <= BIT_LOW;
                                byte_cnt <= byte_cnt + 2'd1;
                            end
                        end else begin
                            state_q <= BIT_LOW;
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                STOP: begin
                    // SDA low, SCL up, then SDA up
                    if (cnt_q == '0) begin
                        sda_o <= 1'b0;
                    end
                    if (cnt_q == cnt_w'(SCL_DIV - 1)) begin
                        scl_o <= 1'b1;
                    end
                    if (cnt_q == cnt_w'(2 * SCL_DIV - 1)) begin
                        state_q <= GAP;
                        cnt_q   <= '0;
                        sda_o   <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

    ////////////////////
    // Payload shifter
    ////////////////////
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE || state_q == GAP) && cnt_q == cnt_w'(GAP_CYCLES - 1)) begin
            // Word captured once per frame
            word_q  <= word_i;
            shift_q <= {exp_addr, 1'b0};
        end else if (state_q == BIT_HIGH && cnt_q == cnt_w'(SCL_DIV - 1)) begin
            if (bit_cnt == 4'd8) begin
                shift_q <= next_byte;
            end else begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

/* overrange_stretch.sv */
`timescale 1ns/100ps
`default_nettype none

module overrange_stretch #(
    parameter int STRETCH_CYCLES = 2048
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic dor_i,
    output logic      flag_o
);

    // Counter wide enough for the full hold
    localparam int cnt_w = $clog2(STRETCH_CYCLES + 1);

    logic [cnt_w-1:0] hold_cnt;

    ////////////////////
    // Hold counter
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_cnt <= '0;
        end else if (dor_i) begin
            // Each overrange sample restarts the hold
            hold_cnt <= cnt_w'(STRETCH_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Visible while any count is left
    assign flag_o = (hold_cnt != '0);

endmodule

`default_nettype wire

/* panel_pkg.sv */
`default_nettype none

package panel_pkg;

    ////////////////////
    // Field widths
    ////////////////////
    localparam int att_w = 2;
    localparam int led_w = 3;
    localparam int port_w = 16;

    // Expander addressing
    localparam logic [6:0] exp_addr = 7'h20;
    localparam logic [7:0] exp_cmd_out0 = 8'h02;

    // LED bits inside the register
    localparam int led_red = 2;
    localparam int led_green = 1;
    localparam int led_blue = 0;

    ////////////////////
    // Port word layout
    ////////////////////
    // Port 0 in bits 7..0
    localparam int pos_amp_a = 6;
    localparam int pos_att_a = 4;
    localparam int pos_amp_b = 2;
    localparam int pos_att_b = 0;
    // Port 1 in bits 15..8
    localparam int pos_red_a = 14;
    localparam int pos_red_b = 13;
    localparam int pos_green_b = 11;
    localparam int pos_blue_b = 10;
    localparam int pos_green_a = 9;
    localparam int pos_blue_a = 8;

    // I2C writer states
    typedef enum logic [2:0] {
        IDLE,
        START,
        BIT_LOW,
        BIT_HIGH,
        STOP,
        GAP
    } i2c_state_e;

endpackage

`default_nettype wire

/* panel_word.sv */
`timescale 1ns/100ps
`default_nettype none

module panel_word (
    input  wire logic [panel_pkg::att_w-1:0]  att_a_i,
    input  wire logic                         amp_a_i,
    input  wire logic [panel_pkg::led_w-1:0]  led_a_i,
    input  wire logic                         ovr_a_i,
    input  wire logic [panel_pkg::att_w-1:0]  att_b_i,
    input  wire logic                         amp_b_i,
    input  wire logic [panel_pkg::led_w-1:0]  led_b_i,
    input  wire logic                         ovr_b_i,
    output logic      [panel_pkg::port_w-1:0] word_o
);

    import panel_pkg::*;

    logic [led_w-1:0] led_a_n;
    logic [led_w-1:0] led_b_n;

    // Active low LED drive, red forced on during overrange
    function automatic logic [led_w-1:0] led_drive(input logic [led_w-1:0] led,
                                                  input logic ovr);
        logic [led_w-1:0] drv;
        drv = ~led;
        if (ovr) begin
            drv[led_red]   = 1'b0;
            drv[led_green] = 1'b1;
            drv[led_blue]  = 1'b1;
        end
        return drv;
    endfunction

    assign led_a_n = led_drive(led_a_i, ovr_a_i);
    assign led_b_n = led_drive(led_b_i, ovr_b_i);

    ////////////////////
    // Port word build
    ////////////////////
    always_comb begin
        // Unused expander pins stay low
        word_o = '0;
        // Port 0, amps and inverted attenuators
        word_o[pos_amp_a]           = amp_a_i;
        word_o[pos_att_a +: att_w]  = ~att_a_i;
        word_o[pos_amp_b]           = amp_b_i;
        word_o[pos_att_b +: att_w]  = ~att_b_i;
        // Port 1, LEDs
        word_o[pos_red_a]   = led_a_n[led_red];
        word_o[pos_green_a] = led_a_n[led_green];
        word_o[pos_blue_a]  = led_a_n[led_blue];
        word_o[pos_red_b]   = led_b_n[led_red];
        word_o[pos_green_b] = led_b_n[led_green];
        word_o[pos_blue_b]  = led_b_n[led_blue];
    end

endmodule

`default_nettype wire

/* sources.f */
bus_pkg.sv
panel_pkg.sv
apb_slot_decode.sv
chan_regs.sv
overrange_stretch.sv
panel_word.sv
ioexp_writer.sv
adc_panel_top.sv
tb_adc_panel_asserts.sv
tb_adc_panel.sv

/* tb_adc_panel.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_adc_panel;

    import bus_pkg::*;
    import panel_pkg::*;

    localparam int scl_div = 4;
    localparam int stretch_cycles = 2048;
    localparam int gap_cycles = 16;
    // Start hold, 36 clocked bits, stop and idle gap
    localparam int frame_cycles = scl_div + 36 * 2 * scl_div + 2 * scl_div + gap_cycles;
    localparam int wait_limit = 3 * frame_cycles;
    localparam int ready_limit = 16;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic [31:0] paddr;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        adc_dora;
    logic        adc_dorb;
    logic        scl;
    logic        sda;

    integer seed;
    int     err_cnt = 0;
    int     timeout_cnt = 0;

    // Shadow copies of the 3-bit CTRL and LED fields
    logic [2:0] sh_ctrl [2];
    logic [2:0] sh_led [2];
    logic       exp_ovr [2];

    // I2C monitor state
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_frame = 1'b0;
    int          nbits = 0;
    logic [35:0] bits_q = '0;
    logic [7:0]  frame_b [4];
    int          start_cnt = 0;
    int          done_idx = 0;

    adc_panel_top #(
        .SCL_DIV        (scl_div),
        .STRETCH_CYCLES (stretch_cycles),
        .GAP_CYCLES     (gap_cycles)
    ) i_adc_panel_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .psel_i       (psel),
        .penable_i    (penable),
        .paddr_i      (paddr),
        .pwrite_i     (pwrite),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .adc_dora_i   (adc_dora),
        .adc_dorb_i   (adc_dorb),
        .adc_io_scl_o (scl),
        .adc_io_sda_o (sda)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    function automatic logic [31:0] reg_addr(input int ch, input logic [11:0] off);
        logic [3:0] slot;
        slot = (ch == 0) ? SLOT_INA : SLOT_INB;
        return {slot_base[19:4], slot, off};
    endfunction

    // Expander word from the mapping rule with active low LEDs
    function automatic logic [15:0] calc_port_word(input logic [2:0] ctrl_a,
        input logic [2:0] led_a, input logic ovr_a, input logic [2:0] ctrl_b,
        input logic [2:0] led_b, input logic ovr_b);
        logic [2:0] drv_a;
        logic [2:0] drv_b;
        logic [7:0] p0;
        logic [7:0] p1;
        // Overrange lights red and darkens green and blue
        drv_a = ovr_a ? 3'b011 : ~led_a;
        drv_b = ovr_b ? 3'b011 : ~led_b;
        p0 = {1'b0, ctrl_a[2], ~ctrl_a[1], ~ctrl_a[0], 1'b0, ctrl_b[2], ~ctrl_b[1], ~ctrl_b[0]};
        p1 = {1'b0, drv_a[2], drv_b[2], 1'b0, drv_b[1], drv_b[0], drv_a[1], drv_a[0]};
        return {p1, p0};
    endfunction

    ////////////////////
    // APB master
    ////////////////////
    task automatic wait_ready();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < ready_limit && !seen; n++) begin
            @(negedge clk);
            seen = pready;
        end
        if (!seen) begin
            $display("Timeout waiting for pready in the APB access phase");
            timeout_cnt++;
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        wait_ready();
        // Write lands on this edge
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        wait_ready();
        // Sampled mid access phase
        data = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] data;
        apb_read(addr, data);
        check_value(name, data, exp);
    endtask

    task automatic check_reset_state();
        for (int ch = 0; ch < 2; ch++) begin
            read_expect(reg_addr(ch, REG_CTRL), ctrl_reset, $sformatf("prdata ch%0d ctrl", ch));
            read_expect(reg_addr(ch, REG_LED), ctrl_reset, $sformatf("prdata ch%0d led", ch));
            read_expect(reg_addr(ch, REG_STATUS), 32'h0, $sformatf("prdata ch%0d status", ch));
        end
    endtask

    ////////////////////
    // I2C monitor
    ////////////////////
    // Lines move on the rising clock and are looked at on the falling one
    always @(negedge clk) begin
        if (!rst_n) begin
            in_frame = 1'b0;
            nbits = 0;
        end else if (prev_scl && scl && prev_sda && !sda) begin
            // START
            in_frame = 1'b1;
            nbits = 0;
            start_cnt++;
        end else if (in_frame && prev_scl && scl && !prev_sda && sda) begin
            // STOP
            in_frame = 1'b0;
            if (nbits != 37) begin
                $display("I2C frame %0d stopped after %0d SCL clocks instead of 37",
                         start_cnt, nbits);
                err_cnt++;
            end else begin
                for (int k = 0; k < 4; k++) begin
                    frame_b[k] = bits_q[35 - 9 * k -: 8];
                    check_value($sformatf("sda ack %0d", k), {31'h0, bits_q[27 - 9 * k]}, 32'h1);
                end
                check_value("sda addr byte", {24'h0, frame_b[0]}, {24'h0, exp_addr, 1'b0});
                check_value("sda cmd byte", {24'h0, frame_b[1]}, {24'h0, exp_cmd_out0});
                done_idx = start_cnt;
            end
        end else if (in_frame && !prev_scl && scl) begin
            // Store bits on SCL rising and count the STOP clock too
            if (nbits < 36) begin
                bits_q = {bits_q[34:0], sda};
            end
            nbits++;
        end
        prev_scl = scl;
        prev_sda = sda;
    end

    // First complete frame that starts from now on
    task automatic wait_frame(output logic ok);
        int target;
        @(negedge clk);
        #1;
        target = start_cnt + 1;
        ok = 1'b0;
        for (int n = 0; n < wait_limit && !ok; n++) begin
            @(negedge clk);
            #1;
            ok = (done_idx >= target);
        end
        if (!ok) begin
            $display("Timeout waiting for a complete I2C frame");
            timeout_cnt++;
        end
    endtask

    task automatic check_frame(input string tag);
        logic [15:0] exp_word;
        logic        ok;
        exp_word = calc_port_word(sh_ctrl[0], sh_led[0], exp_ovr[0],
                                  sh_ctrl[1], sh_led[1], exp_ovr[1]);
        wait_frame(ok);
        if (ok) begin
            check_value({"sda port0 ", tag}, {24'h0, frame_b[2]}, {24'h0, exp_word[7:0]});
            check_value({"sda port1 ", tag}, {24'h0, frame_b[3]}, {24'h0, exp_word[15:8]});
        end
    endtask

    ////////////////////
    // Scenarios
    ////////////////////
    task automatic check_overrange(input int ch);
        // Green and blue lit so the override flips all three LED bits
        apb_write(reg_addr(ch, REG_LED), 32'h3);
        sh_led[ch] = 3'b011;
        @(posedge clk);
        #2;
        if (ch == 0) begin
            adc_dora = 1'b1;
        end else begin
            adc_dorb = 1'b1;
        end
        @(posedge clk);
        #2;
        adc_dora = 1'b0;
        adc_dorb = 1'b0;
        exp_ovr[ch] = 1'b1;
        read_expect(reg_addr(ch, REG_STATUS), 32'h1, $sformatf("prdata ch%0d status", ch));
        read_expect(reg_addr(1 - ch, REG_STATUS), 32'h0, "prdata other status");
        check_frame("overrange held");
        // Wait out the hold time plus one frame
        repeat (stretch_cycles + frame_cycles) @(posedge clk);
        exp_ovr[ch] = 1'b0;
        read_expect(reg_addr(ch, REG_STATUS), 32'h0, $sformatf("prdata ch%0d status", ch));
        check_frame("overrange released");
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int ch = 0; ch < 2; ch++) begin
            sh_ctrl[ch] = ctrl_reset[2:0];
            sh_led[ch]  = ctrl_reset[2:0];
            exp_ovr[ch] = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        hit;
        int          total;
        seed     = 32'h913;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        paddr    = '0;
        pwrite   = 1'b0;
        pwdata   = '0;
        adc_dora = 1'b0;
        adc_dorb = 1'b0;
        for (int ch = 0; ch < 2; ch++) begin
            sh_ctrl[ch] = ctrl_reset[2:0];
            sh_led[ch]  = ctrl_reset[2:0];
            exp_ovr[ch] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Reset values, unmapped slot and foreign page
        check_reset_state();
        read_expect({slot_base[19:4], 4'h5, 12'h000}, 32'h0, "prdata unmapped slot");
        apb_write({slot_base[19:4], 4'h5, 12'h000}, 32'hFFFF_FFFF);
        apb_write(32'h1234_0000, 32'hFFFF_FFFF);
        read_expect({slot_base[19:4], 4'h5, 12'h000}, 32'h0, "prdata unmapped slot");
        check_reset_state();

        // Random fields, readback and frame content
        for (int round = 0; round < 4; round++) begin
            for (int ch = 0; ch < 2; ch++) begin
                data = $random(seed);
                apb_write(reg_addr(ch, REG_CTRL), data);
                sh_ctrl[ch] = data[2:0];
                data = $random(seed);
                apb_write(reg_addr(ch, REG_LED), data);
                sh_led[ch] = data[2:0];
            end
            for (int ch = 0; ch < 2; ch++) begin
                read_expect(reg_addr(ch, REG_CTRL), {29'h0, sh_ctrl[ch]},
                            $sformatf("prdata ch%0d ctrl", ch));
                read_expect(reg_addr(ch, REG_LED), {29'h0, sh_led[ch]},
                            $sformatf("prdata ch%0d led", ch));
            end
            check_frame("after writes");
        end

        check_overrange(0);
        check_overrange(1);

        // Reset in the middle of a frame
        hit = 1'b0;
        for (int n = 0; n < wait_limit && !hit; n++) begin
            @(negedge clk);
            #1;
            hit = in_frame && (nbits > 10);
        end
        if (!hit) begin
            $display("Timeout waiting for a frame in progress");
            timeout_cnt++;
        end
        reset_dut();
        check_reset_state();
        // Back to back frames after the reset
        for (int n = 0; n < 3; n++) begin
            check_frame("after reset");
        end

        total = err_cnt + timeout_cnt + i_adc_panel_top.i_asserts.fail_cnt;
        $display("Errors: %0d value, %0d timeout, %0d assertion", err_cnt, timeout_cnt,
                 i_adc_panel_top.i_asserts.fail_cnt);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_adc_panel_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_adc_panel_asserts (
    input wire logic                                        clk_i,
    input wire logic                                        rst_n_i,
    input wire logic                                        pready_i,
    input wire logic                                        pslverr_i,
    input wire logic                                        scl_i,
    input wire logic                                        sda_i,
    input wire logic [$bits(panel_pkg::i2c_state_e)-1:0]    wr_state_i
);

    import panel_pkg::*;

    // Failures seen so far, read by the testbench top
    int fail_cnt = 0;

    ////////////////////
    // APB response
    ////////////////////
    a_apb_resp: assert property (@(posedge clk_i) pready_i && !pslverr_i)
        else begin
            fail_cnt++;
            $error("APB slave not ready or returned an error");
        end

    ////////////////////
    // I2C lines
    ////////////////////
    // Both lines released one cycle into reset
    a_idle_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> (scl_i && sda_i))
        else begin
            fail_cnt++;
            $error("SCL or SDA low while in reset");
        end

    // Under high SCL, SDA may only fall for START or rise for STOP
    a_sda_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (scl_i && $past(scl_i) && (sda_i != $past(sda_i)))
        |-> ((wr_state_i == START && !sda_i) || (wr_state_i == GAP && sda_i)))
        else begin
            fail_cnt++;
            $error("SDA changed under high SCL outside START or STOP");
        end

endmodule

bind adc_panel_top tb_adc_panel_asserts i_asserts (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pready_i   (pready_o),
    .pslverr_i  (pslverr_o),
    .scl_i      (adc_io_scl_o),
    .sda_i      (adc_io_sda_o),
    .wr_state_i (i_ioexp_writer.state_q)
);

`default_nettype wire
